// File: verilog.f
isa_pkg.sv
tomasulo_pkg.sv
operand_if.sv
operand_resolver.sv
issue_fsm.sv
rob_tag_counter.sv
dispatch_builder.sv
issue_unit.sv
tb_issue_unit.sv

// File: run_sim.sh
#!/bin/sh

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_issue_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_issue_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
	exit 0
else
	exit 1
fi

// File: tb_issue_unit.sv
module tb_issue_unit;
	timeunit 1ns;
	timeprecision 1ps;
	import isa_pkg::*;
	import tomasulo_pkg::*;

	localparam int NUM_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + 50;   // Test length plus margin

	typedef struct packed {
		word_t value;
		logic valid;
		tag_t tag;
	} operand_t;

	typedef struct packed {
		logic stall;
		reg_t sr1_sel;
		reg_t sr2_sel;
		logic rs_write;
		station_id_t rs_station;
		operand_t rs_j;
		operand_t rs_k;
		logic ldst_write;
		logic ldst_store;
		word_t ldst_offset;
		operand_t ldst_base;
		operand_t ldst_src;
		logic rob_write;
		opcode_t rob_op;
		reg_t rob_dest;
		logic reg_busy_write;
		reg_t reg_dest;
		tag_t issue_tag;
	} expect_t;

	logic clk, reset, flush, instr_valid, stall;
	instr_u instr;
	reg_t sr1_sel, sr2_sel, rob_dest, reg_dest;
	logic sr1_busy, sr2_busy, rob_sr1_valid, rob_sr2_valid, cdb_valid;
	word_t sr1_data, sr2_data, rob_sr1_value, rob_sr2_value, cdb_data;
	tag_t sr1_tag, sr2_tag, cdb_tag, rs_qj, rs_qk, ldst_qbase, ldst_qsrc, issue_tag;
	logic [NUM_ALU_STATIONS-1:0] alu_busy;
	logic ldst_full, rob_full, rs_write, rs_vj_valid, rs_vk_valid;
	station_id_t rs_station;
	opcode_t rs_op, rob_op;
	word_t rs_vj, rs_vk, ldst_offset, ldst_vbase, ldst_vsrc;
	logic ldst_write, ldst_store, ldst_vbase_valid, ldst_vsrc_valid, rob_write, reg_busy_write;

	// Model state
	tag_t model_tag;
	issue_phase_t model_phase;
	tag_t model_ptr;
	logic hold;               // Fetch keeps the word after a stall
	expect_t exp_cur;
	integer seed = 12;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	issue_unit i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Priority: register file, CDB, ROB, then wait on the producer tag
	function automatic operand_t resolve(input logic busy, input word_t data, input tag_t tag,
		input logic rvalid, input word_t rvalue);
		operand_t r;
		r.value = data;
		r.valid = 1'b1;
		r.tag = '0;
		if (busy)
		begin
			if (cdb_valid && (cdb_tag == tag))
				r.value = cdb_data;
			else if (rvalid)
				r.value = rvalue;
			else
			begin
				r.value = '0;
				r.valid = 1'b0;
				r.tag = tag;
			end
		end
		return r;
	endfunction

	// Expected issue outputs from the current inputs and model state
	function automatic expect_t reference(input logic [15:0] w, input tag_t m_tag,
		input issue_phase_t m_phase, input tag_t m_ptr);
		expect_t e;
		opcode_t op;
		logic alu_op, mem_op, store, ldi, second, blocked, ptr_hit;
		operand_t a, b;
		op = opcode_t'(w[15:12]);
		alu_op = (op == op_add) || (op == op_and) || (op == op_not);
		store = (op == op_str);
		ldi = (op == op_ldi);
		mem_op = store || ldi || (op == op_ldr);
		second = ldi && (m_phase == phase_ldi_second);
		blocked = rob_full || (alu_op && (alu_busy == 3'b111)) || (mem_op && ldst_full);
		a = resolve(sr1_busy, sr1_data, sr1_tag, rob_sr1_valid, rob_sr1_value);
		b = resolve(sr2_busy, sr2_data, sr2_tag, rob_sr2_valid, rob_sr2_value);
		e = '0;
		e.sr1_sel = w[8:6];
		e.sr2_sel = store ? w[11:9] : w[2:0];
		e.stall = instr_valid && (blocked || (ldi && !second));
		e.rob_write = instr_valid && !blocked;
		e.rs_write = e.rob_write && alu_op;
		e.rs_station = !alu_busy[0] ? 2'd0 : (!alu_busy[1] ? 2'd1 : 2'd2);
		e.rs_j = a;
		e.rs_k = w[5] ? operand_t'({{11{w[4]}}, w[4:0], 1'b1, 3'd0}) : b;
		e.ldst_write = e.rob_write && mem_op;
		e.ldst_store = store;
		e.ldst_offset = ldi ? 16'h0000 : {{9{w[5]}}, w[5:0], 1'b0};
		e.ldst_base = a;
		if (second)
		begin
			ptr_hit = cdb_valid && (cdb_tag == m_ptr);
			e.ldst_base = ptr_hit ? operand_t'({cdb_data, 1'b1, 3'd0})
				: operand_t'({16'h0000, 1'b0, m_ptr});
		end
		e.ldst_src = b;
		e.rob_op = op;
		e.rob_dest = store ? 3'd0 : w[11:9];
		e.reg_busy_write = e.rob_write && !store && (!ldi || second);
		e.reg_dest = w[11:9];
		e.issue_tag = m_tag;
		return e;
	endfunction

	task automatic check(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		logic [15:0] w;
		opcode_t op;
		r = $random(seed);
		flush = (r[6:2] == 5'd0);
		rob_full = (r[9:7] == 3'd0);
		ldst_full = (r[12:10] == 3'd0);
		alu_busy = r[15:13];
		cdb_valid = r[16];
		sr1_busy = r[17];
		sr2_busy = r[18];
		rob_sr1_valid = r[19];
		rob_sr2_valid = r[20];
		sr1_tag = r[23:21];
		sr2_tag = r[26:24];
		// Aim the CDB at the LDI pointer or at sr1 now and then
		cdb_tag = (r[28:27] == 2'd0) ? model_ptr : ((r[28:27] == 2'd1) ? sr1_tag : r[31:29]);
		r = $random(seed);
		sr1_data = r[15:0];
		sr2_data = r[31:16];
		r = $random(seed);
		rob_sr1_value = r[15:0];
		rob_sr2_value = r[31:16];
		r = $random(seed);
		cdb_data = r[15:0];
		if (!hold)
		begin
			case (r[18:16])
				3'd0: op = op_add;
				3'd1: op = op_and;
				3'd2: op = op_not;
				3'd3: op = op_ldr;
				3'd4: op = op_str;
				default: op = op_ldi;
			endcase
			w = {op, r[31:20]};
			if (op == op_not)
				w[5:0] = 6'h3f;                   // NOT encodes all ones here
			instr = w;
			instr_valid = (r[1:0] != 2'b00);
		end
	endtask

	always @(negedge clk)
		drive_inputs();

	// Compare one step before the rising edge
	always @(negedge clk)
	begin
		#49;
		exp_cur = reference(instr, model_tag, model_phase, model_ptr);
		if (!reset)
		begin
			check("stall", 16'(stall), 16'(exp_cur.stall));
			check("sr1_sel", 16'(sr1_sel), 16'(exp_cur.sr1_sel));
			check("sr2_sel", 16'(sr2_sel), 16'(exp_cur.sr2_sel));
			check("issue_tag", 16'(issue_tag), 16'(exp_cur.issue_tag));
			check("rs_write", 16'(rs_write), 16'(exp_cur.rs_write));
			check("ldst_write", 16'(ldst_write), 16'(exp_cur.ldst_write));
			check("rob_write", 16'(rob_write), 16'(exp_cur.rob_write));
			check("reg_busy_write", 16'(reg_busy_write), 16'(exp_cur.reg_busy_write));
			if (exp_cur.rs_write)
			begin
				check("rs_station", 16'(rs_station), 16'(exp_cur.rs_station));
				check("rs_op", 16'(rs_op), 16'(exp_cur.rob_op));
				check("rs_vj_valid", 16'(rs_vj_valid), 16'(exp_cur.rs_j.valid));
				if (exp_cur.rs_j.valid)
					check("rs_vj", rs_vj, exp_cur.rs_j.value);
				else
					check("rs_qj", 16'(rs_qj), 16'(exp_cur.rs_j.tag));
				check("rs_vk_valid", 16'(rs_vk_valid), 16'(exp_cur.rs_k.valid));
				if (exp_cur.rs_k.valid)
					check("rs_vk", rs_vk, exp_cur.rs_k.value);
				else
					check("rs_qk", 16'(rs_qk), 16'(exp_cur.rs_k.tag));
			end
			if (exp_cur.ldst_write)
			begin
				check("ldst_store", 16'(ldst_store), 16'(exp_cur.ldst_store));
				check("ldst_offset", ldst_offset, exp_cur.ldst_offset);
				check("ldst_vbase_valid", 16'(ldst_vbase_valid), 16'(exp_cur.ldst_base.valid));
				if (exp_cur.ldst_base.valid)
					check("ldst_vbase", ldst_vbase, exp_cur.ldst_base.value);
				else
					check("ldst_qbase", 16'(ldst_qbase), 16'(exp_cur.ldst_base.tag));
				if (exp_cur.ldst_store)
				begin
					check("ldst_vsrc_valid", 16'(ldst_vsrc_valid), 16'(exp_cur.ldst_src.valid));
					if (exp_cur.ldst_src.valid)
						check("ldst_vsrc", ldst_vsrc, exp_cur.ldst_src.value);
					else
						check("ldst_qsrc", 16'(ldst_qsrc), 16'(exp_cur.ldst_src.tag));
				end
			end
			if (exp_cur.rob_write)
			begin
				check("rob_op", 16'(rob_op), 16'(exp_cur.rob_op));
				check("rob_dest", 16'(rob_dest), 16'(exp_cur.rob_dest));
			end
			if (exp_cur.reg_busy_write)
				check("reg_dest", 16'(reg_dest), 16'(exp_cur.reg_dest));
		end
	end

	always @(posedge clk)
	begin
		hold <= !reset && instr_valid && exp_cur.stall;
		if (reset || flush)
		begin
			model_tag <= '0;
			model_phase <= phase_normal;
		end
		else if (exp_cur.rob_write)
		begin
			model_tag <= (model_tag == 3'd7) ? 3'd0 : model_tag + 3'd1;
			if ((instr[15:12] == op_ldi) && (model_phase == phase_normal))
			begin
				model_phase <= phase_ldi_second;
				model_ptr <= model_tag;         // Pointer load tag
			end
			else if (instr[15:12] == op_ldi)
				model_phase <= phase_normal;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		reset = 1'b1;
		flush = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		{sr1_busy, sr2_busy, rob_sr1_valid, rob_sr2_valid, cdb_valid} = '0;
		{sr1_data, sr2_data, rob_sr1_value, rob_sr2_value, cdb_data} = '0;
		{sr1_tag, sr2_tag, cdb_tag} = '0;
		{alu_busy, ldst_full, rob_full} = '0;
		{model_tag, model_ptr, hold} = '0;
		model_phase = phase_normal;
		repeat (2) @(posedge clk);
		@(negedge clk) reset = 1'b0;
		repeat (NUM_CYCLES / 2) @(posedge clk);
		@(negedge clk) reset = 1'b1;    // Second reset mid-run
		repeat (2) @(posedge clk);
		@(negedge clk) reset = 1'b0;
		repeat (NUM_CYCLES / 2) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: issue_unit.sv
module issue_unit (
	input logic clk,
	input logic reset,
	input logic flush,
	input isa_pkg::instr_u instr,
	input logic instr_valid,
	output logic stall,
	output isa_pkg::reg_t sr1_sel,
	output isa_pkg::reg_t sr2_sel,
	input logic sr1_busy,
	input isa_pkg::word_t sr1_data,
	input tomasulo_pkg::tag_t sr1_tag,
	input logic sr2_busy,
	input isa_pkg::word_t sr2_data,
	input tomasulo_pkg::tag_t sr2_tag,
	input logic rob_sr1_valid,
	input isa_pkg::word_t rob_sr1_value,
	input logic rob_sr2_valid,
	input isa_pkg::word_t rob_sr2_value,
	input logic cdb_valid,
	input tomasulo_pkg::tag_t cdb_tag,
	input isa_pkg::word_t cdb_data,
	input logic [tomasulo_pkg::NUM_ALU_STATIONS-1:0] alu_busy,
	input logic ldst_full,
	input logic rob_full,
	output logic rs_write,
	output tomasulo_pkg::station_id_t rs_station,
	output isa_pkg::opcode_t rs_op,
	output isa_pkg::word_t rs_vj,
	output isa_pkg::word_t rs_vk,
	output logic rs_vj_valid,
	output logic rs_vk_valid,
	output tomasulo_pkg::tag_t rs_qj,
	output tomasulo_pkg::tag_t rs_qk,
	output logic ldst_write,
	output logic ldst_store,
	output isa_pkg::word_t ldst_offset,
	output isa_pkg::word_t ldst_vbase,
	output logic ldst_vbase_valid,
	output tomasulo_pkg::tag_t ldst_qbase,
	output isa_pkg::word_t ldst_vsrc,
	output logic ldst_vsrc_valid,
	output tomasulo_pkg::tag_t ldst_qsrc,
	output logic rob_write,
	output isa_pkg::opcode_t rob_op,
	output isa_pkg::reg_t rob_dest,
	output logic reg_busy_write,
	output isa_pkg::reg_t reg_dest,
	output tomasulo_pkg::tag_t issue_tag    // ROB entry and rename tag of this issue
);
	import tomasulo_pkg::*;

	logic issue_go;
	issue_phase_t phase;
	tag_t pointer_tag;

	operand_if op1 (.clk(clk));
	operand_if op2 (.clk(clk));

	// Register file and ROB lookups into the operand bundles
	assign op1.reg_busy = sr1_busy;
	assign op1.reg_data = sr1_data;
	assign op1.reg_tag = sr1_tag;
	assign op1.rob_valid = rob_sr1_valid;
	assign op1.rob_value = rob_sr1_value;
	assign op2.reg_busy = sr2_busy;
	assign op2.reg_data = sr2_data;
	assign op2.reg_tag = sr2_tag;
	assign op2.rob_valid = rob_sr2_valid;
	assign op2.rob_value = rob_sr2_value;

	operand_resolver u_resolve1 (
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.op(op1)
	);

	operand_resolver u_resolve2 (
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.op(op2)
	);

	issue_fsm u_fsm (.*);

	rob_tag_counter u_tag (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.advance(rob_write),
		.tag(issue_tag)
	);

	dispatch_builder u_dispatch (.*);

endmodule

// File: dispatch_builder.sv
module dispatch_builder (
	input isa_pkg::instr_u instr,
	input logic issue_go,
	input tomasulo_pkg::issue_phase_t phase,
	input tomasulo_pkg::tag_t pointer_tag,
	input logic [tomasulo_pkg::NUM_ALU_STATIONS-1:0] alu_busy,
	input logic cdb_valid,
	input tomasulo_pkg::tag_t cdb_tag,
	input isa_pkg::word_t cdb_data,
	operand_if.consumer op1,
	operand_if.consumer op2,
	output logic rs_write,
	output tomasulo_pkg::station_id_t rs_station,
	output isa_pkg::opcode_t rs_op,
	output isa_pkg::word_t rs_vj,
	output isa_pkg::word_t rs_vk,
	output logic rs_vj_valid,
	output logic rs_vk_valid,
	output tomasulo_pkg::tag_t rs_qj,
	output tomasulo_pkg::tag_t rs_qk,
	output logic ldst_write,
	output logic ldst_store,
	output isa_pkg::word_t ldst_offset,
	output isa_pkg::word_t ldst_vbase,
	output logic ldst_vbase_valid,
	output tomasulo_pkg::tag_t ldst_qbase,
	output isa_pkg::word_t ldst_vsrc,
	output logic ldst_vsrc_valid,
	output tomasulo_pkg::tag_t ldst_qsrc,
	output logic rob_write,
	output isa_pkg::opcode_t rob_op,
	output isa_pkg::reg_t rob_dest,
	output logic reg_busy_write,
	output isa_pkg::reg_t reg_dest,
	output isa_pkg::reg_t sr1_sel,
	output isa_pkg::reg_t sr2_sel
);
	import isa_pkg::*;
	import tomasulo_pkg::*;

	opcode_t opcode;
	logic is_alu;
	logic is_mem;
	logic is_store;
	logic is_ldi;
	logic ldi_second;
	logic pointer_on_cdb;
	word_t imm5_sext;
	word_t offset_scaled;
	station_id_t free_station;

	assign opcode = instr.alu.opcode;
	assign is_alu = opcode inside {op_add, op_and, op_not};
	assign is_store = (opcode == op_str);
	assign is_ldi = (opcode == op_ldi);
	assign is_mem = is_store || is_ldi || (opcode == op_ldr);
	assign ldi_second = is_ldi && (phase == phase_ldi_second);
	assign pointer_on_cdb = cdb_valid && (cdb_tag == pointer_tag);

	// STR reads its source register through the second port
	assign sr1_sel = instr.alu.sr1;   // Same bits as the memory base
	assign sr2_sel = is_store ? instr.mem.dr : instr.alu.src2[REG_W-1:0];

	assign imm5_sext = {{(WORD_W - IMM5_W){instr.alu.src2[IMM5_W-1]}}, instr.alu.src2};
	assign offset_scaled = {{(WORD_W - OFFSET6_W - 1){instr.mem.offset6[OFFSET6_W-1]}},
		instr.mem.offset6, 1'b0};   // Word offset to byte offset

	// Lowest numbered free station wins
	always_comb
	begin
		free_station = '0;
		for (int i = NUM_ALU_STATIONS - 1; i >= 0; i--)
		begin
			if (!alu_busy[i])
				free_station = station_id_t'(i);
		end
	end

	assign rs_write = issue_go && is_alu;
	assign rs_station = free_station;
	assign rs_op = opcode;
	assign rs_vj = op1.value;
	assign rs_vj_valid = op1.value_valid;
	assign rs_qj = op1.wait_tag;
	assign rs_vk = instr.alu.imm ? imm5_sext : op2.value;
	assign rs_vk_valid = instr.alu.imm || op2.value_valid;
	assign rs_qk = instr.alu.imm ? '0 : op2.wait_tag;

	assign ldst_write = issue_go && is_mem;
	assign ldst_store = is_store;
	assign ldst_offset = is_ldi ? '0 : offset_scaled;   // Both LDI loads use offset 0

	always_comb
	begin
		if (ldi_second)
		begin
			// Base is the pointer load's result
			ldst_vbase = pointer_on_cdb ? cdb_data : '0;
			ldst_vbase_valid = pointer_on_cdb;
			ldst_qbase = pointer_on_cdb ? '0 : pointer_tag;
		end
		else
		begin
			ldst_vbase = op1.value;
			ldst_vbase_valid = op1.value_valid;
			ldst_qbase = op1.wait_tag;
		end
	end

	assign ldst_vsrc = is_store ? op2.value : '0;
	assign ldst_vsrc_valid = is_store && op2.value_valid;
	assign ldst_qsrc = is_store ? op2.wait_tag : '0;

	// Every issue takes an ROB entry, the LDI pointer load too
	assign rob_write = issue_go;
	assign rob_op = opcode;
	assign rob_dest = is_store ? '0 : instr.alu.dr;

	// Pointer load does not rename dr
	assign reg_busy_write = issue_go && !is_store && (!is_ldi || ldi_second);
	assign reg_dest = instr.alu.dr;

endmodule

// File: rob_tag_counter.sv
module rob_tag_counter (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic advance,
	output tomasulo_pkg::tag_t tag
);
	import tomasulo_pkg::*;

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			tag <= '0;
		else if (advance)
		begin
			if (tag == tag_t'(ROB_DEPTH - 1))
				tag <= '0;                 // Wrap to the first ROB entry
			else
				tag <= tag + 1'b1;
		end
	end

	// Tag only moves on an ROB write, reset or flush
	assert property (@(posedge clk)
		!(reset || flush || advance) |=> $stable(tag));

endmodule

// File: issue_fsm.sv
module issue_fsm (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic instr_valid,
	input isa_pkg::instr_u instr,
	input logic [tomasulo_pkg::NUM_ALU_STATIONS-1:0] alu_busy,
	input logic ldst_full,
	input logic rob_full,
	input tomasulo_pkg::tag_t issue_tag,
	output logic stall,
	output logic issue_go,
	output tomasulo_pkg::issue_phase_t phase,
	output tomasulo_pkg::tag_t pointer_tag
);
	import isa_pkg::*;
	import tomasulo_pkg::*;

	opcode_t opcode;
	logic is_alu;
	logic is_mem;
	logic blocked;
	logic ldi_first;

	assign opcode = instr.alu.opcode;

	always_comb
	begin
		is_alu = 1'b0;
		is_mem = 1'b0;
		case (opcode)
			op_add, op_and, op_not: is_alu = 1'b1;
			op_ldr, op_str, op_ldi: is_mem = 1'b1;
			default: ;                        // Not issued by this stage
		endcase
	end

	// Back-pressure for the class of the waiting instruction
	assign blocked = rob_full || (is_alu && (&alu_busy)) || (is_mem && ldst_full);

	assign ldi_first = (opcode == op_ldi) && (phase == phase_normal);

	assign issue_go = instr_valid && (is_alu || is_mem) && !blocked;

	// First LDI issue writes but keeps the word held at fetch
	assign stall = instr_valid && (blocked || ldi_first);

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			phase <= phase_normal;
		else if (issue_go && (opcode == op_ldi))
		begin
			if (ldi_first)
				phase <= phase_ldi_second;
			else
				phase <= phase_normal;
		end
	end

	// Tag of the pointer load, base of the second issue
	always_ff @(posedge clk)
	begin
		if (issue_go && ldi_first)
			pointer_tag <= issue_tag;
	end

	// Fetch holds the LDI word while its second issue is pending
	assert property (@(posedge clk) disable iff (reset || flush)
		(phase == phase_ldi_second) |-> instr_valid && (opcode == op_ldi));

endmodule

// File: operand_resolver.sv
module operand_resolver (
	input logic cdb_valid,
	input tomasulo_pkg::tag_t cdb_tag,
	input isa_pkg::word_t cdb_data,
	operand_if.resolver op
);

	logic cdb_hit;

	// Producer is broadcasting right now
	assign cdb_hit = cdb_valid && (cdb_tag == op.reg_tag);

	always_comb
	begin
		op.value = op.reg_data;
		op.value_valid = 1'b1;
		op.wait_tag = '0;
		if (op.reg_busy)
		begin
			if (cdb_hit)
				op.value = cdb_data;
			else if (op.rob_valid)
				op.value = op.rob_value;   // Done but not yet committed
			else
			begin
				op.value = '0;
				op.value_valid = 1'b0;
				op.wait_tag = op.reg_tag;
			end
		end
	end

	// A waiting operand must name a producer that has no value anywhere yet
	assert property (@(posedge op.clk)
		!op.value_valid |-> op.reg_busy && !cdb_hit && !op.rob_valid
			&& (op.wait_tag == op.reg_tag));

endmodule

// File: operand_if.sv
interface operand_if (
	input logic clk
);
	import isa_pkg::*;
	import tomasulo_pkg::*;

	// Register file and ROB lookups for this source
	logic reg_busy;
	word_t reg_data;
	tag_t reg_tag;
	logic rob_valid;
	word_t rob_value;

	// Resolved operand
	word_t value;
	logic value_valid;
	tag_t wait_tag;       // Producer tag when value is not ready

	modport resolver (
		input clk,
		input reg_busy,
		input reg_data,
		input reg_tag,
		input rob_valid,
		input rob_value,
		output value,
		output value_valid,
		output wait_tag
	);

	modport consumer (
		input value,
		input value_valid,
		input wait_tag
	);

endinterface

// File: tomasulo_pkg.sv
package tomasulo_pkg;

	localparam int TAG_W = 3;
	localparam int ROB_DEPTH = 1 << TAG_W;
	localparam int NUM_ALU_STATIONS = 3;
	localparam int STATION_W = $clog2(NUM_ALU_STATIONS);

	// ROB entry index, also the rename tag
	typedef logic [TAG_W-1:0] tag_t;

	typedef logic [STATION_W-1:0] station_id_t;

	// Second phase exists only for the LDI double issue
	typedef enum logic {
		phase_normal,
		phase_ldi_second
	} issue_phase_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

	localparam int OPCODE_W = 4;
	localparam int REG_W = 3;
	localparam int WORD_W = 16;
	localparam int IMM5_W = 5;
	localparam int OFFSET6_W = 6;

	// LC-3b opcode map
	typedef enum logic [OPCODE_W-1:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} opcode_t;

	typedef logic [REG_W-1:0] reg_t;
	typedef logic [WORD_W-1:0] word_t;

	// ADD, AND, NOT
	typedef struct packed {
		opcode_t opcode;
		reg_t dr;
		reg_t sr1;
		logic imm;                // Bit 5
		logic [IMM5_W-1:0] src2;  // imm5, or sr2 in the low three bits
	} alu_fmt_t;

	// LDR, STR, LDI
	typedef struct packed {
		opcode_t opcode;
		reg_t dr;                 // Source register for STR
		reg_t base;
		logic [OFFSET6_W-1:0] offset6;
	} mem_fmt_t;

	typedef union packed {
		alu_fmt_t alu;
		mem_fmt_t mem;
	} instr_u;

endpackage
